//--- source/bp_defs.svh
////////////////////////////////////////////////////////////////////////////
// branch predictor geometry
// table size, PC width and tag layout shared by every block of the
// branch history table
////////////////////////////////////////////////////////////////////////////

`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// halfword program counter width
`define BP_PC_W 11

// set index bits, taken from the low PC bits
`define BP_SET_W 4

// associativity of the table
`define BP_WAYS 4
`define BP_WAY_W 2

// tag is the ISR-running bit on top of PC bits 10..4
`define BP_TAG_W 8

`endif

//--- source/bp_entry_pkg.sv
////////////////////////////////////////////////////////////////////////////
// branch history table entry types
// stored entry layout, lookup key and per-way vectors
////////////////////////////////////////////////////////////////////////////

`include "bp_defs.svh"

package bp_entry_pkg;

	// one table line, 22 bits
	// valid | tag | predicted target | saturating counter
	typedef struct packed {
		logic                  valid;
		logic [`BP_TAG_W-1:0]  tag;
		logic [`BP_PC_W-1:0]   target;
		logic [1:0]            ctr;
	} bht_entry_t;

	// lookup key formed from a PC and the ISR bit, 12 bits
	typedef struct packed {
		logic [`BP_SET_W-1:0]  set;
		logic [`BP_TAG_W-1:0]  tag;
	} bht_key_t;

	// one bit per way, used for hit and write-enable vectors
	typedef logic [`BP_WAYS-1:0] way_vec_t;

	// the entries of all ways for one set
	typedef bht_entry_t [`BP_WAYS-1:0] entry_vec_t;

endpackage

//--- source/bp_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// branch predictor control types
// branch opcodes, next-PC correction codes and stage request bundles
////////////////////////////////////////////////////////////////////////////

`include "bp_defs.svh"

package bp_ctrl_pkg;

	// conditional branch kind decoded in EXE
	typedef enum logic [3:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU,
		BR_C_BEQZ,
		BR_C_BNEZ
	} br_op_e;

	// next-PC correction select
	// 00 keeps the sequential PC, 10 takes CNI, 11 takes PBT
	typedef enum logic [1:0] {
		CORR_NONE = 2'b00,
		CORR_CNI  = 2'b10,
		CORR_PBT  = 2'b11
	} correction_e;

	// decode stage request, allocation source
	typedef struct packed {
		logic [`BP_PC_W-1:0]  pc;
		logic [`BP_PC_W-1:0]  target;
		logic                 is_jump;
		logic                 is_branch;
	} id_req_t;

	// execute stage request with the ALU compare flags
	typedef struct packed {
		logic [`BP_PC_W-1:0]  pc;
		logic [`BP_PC_W-1:0]  target;
		br_op_e               op;
		// JALR, C.JR and C.JALR, whose target comes from a register
		logic                 is_indirect;
		logic                 z;
		logic                 less;
		logic                 signed_less;
	} exe_req_t;

	// table rewrite produced by branch resolution
	typedef struct packed {
		logic                     valid;
		logic [`BP_SET_W-1:0]     set;
		logic [`BP_WAY_W-1:0]     way;
		bp_entry_pkg::bht_entry_t entry;
	} bht_update_t;

endpackage

//--- source/bht_way.sv
////////////////////////////////////////////////////////////////////////////
// branch history table way
// 16 entries with IF, ID and EXE tag-compare read ports and one write port
////////////////////////////////////////////////////////////////////////////

`include "bp_defs.svh"

module bht_way (
	input  logic                     CLK,
	input  logic                     nrst,
	input  bp_entry_pkg::bht_key_t   if_key,
	input  bp_entry_pkg::bht_key_t   id_key,
	input  bp_entry_pkg::bht_key_t   exe_key,
	input  logic                     wr_en,
	input  logic [`BP_SET_W-1:0]     wr_set,
	input  bp_entry_pkg::bht_entry_t wr_entry,
	output logic                     if_hit,
	output logic                     id_hit,
	output logic                     exe_hit,
	output bp_entry_pkg::bht_entry_t if_entry,
	output bp_entry_pkg::bht_entry_t exe_entry
);

	localparam int SETS = 1 << `BP_SET_W;

	// valid bits live apart from the payload array
	logic [SETS-1:0]          valid_q;
	bp_entry_pkg::bht_entry_t mem [SETS];

	bp_entry_pkg::bht_entry_t if_rd;
	bp_entry_pkg::bht_entry_t id_rd;
	bp_entry_pkg::bht_entry_t exe_rd;

	// valid flags, cleared on reset
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			valid_q <= '0;
		end else if (wr_en) begin
			valid_q[wr_set] <= wr_entry.valid;
		end
	end

	// tag, target and counter payload
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_set] <= wr_entry;
		end
	end

	// asynchronous reads, one per pipeline stage
	always_comb begin
		if_rd        = mem[if_key.set];
		if_rd.valid  = valid_q[if_key.set];
		id_rd        = mem[id_key.set];
		id_rd.valid  = valid_q[id_key.set];
		exe_rd       = mem[exe_key.set];
		exe_rd.valid = valid_q[exe_key.set];
	end

	// hit needs a live entry with a matching tag
	assign if_hit  = if_rd.valid && (if_rd.tag == if_key.tag);
	assign id_hit  = id_rd.valid && (id_rd.tag == id_key.tag);
	assign exe_hit = exe_rd.valid && (exe_rd.tag == exe_key.tag);

	assign if_entry  = if_rd;
	assign exe_entry = exe_rd;

endmodule

//--- source/bht_fill_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// branch history table fill controller
// allocates ID-stage misses with FIFO replacement per set and arbitrates
// the single table write port against EXE updates
////////////////////////////////////////////////////////////////////////////

`include "bp_defs.svh"

module bht_fill_ctrl (
	input  logic                      CLK,
	input  logic                      nrst,
	input  logic                      stall,
	input  bp_ctrl_pkg::id_req_t      id_req,
	input  logic [`BP_SET_W-1:0]      id_set,
	input  logic [`BP_TAG_W-1:0]      id_tag,
	input  bp_entry_pkg::way_vec_t    id_hit,
	input  bp_ctrl_pkg::bht_update_t  update,
	output bp_entry_pkg::way_vec_t    way_wr_en,
	output logic [`BP_SET_W-1:0]      wr_set,
	output bp_entry_pkg::bht_entry_t  wr_entry,
	output logic                      jump_flush,
	output logic                      id_jump_in_bht
);

	localparam int SETS = 1 << `BP_SET_W;

	// next victim way of each set
	logic [`BP_WAY_W-1:0] fifo_q [SETS];

	logic                     id_miss;
	logic                     alloc;
	bp_entry_pkg::bht_entry_t alloc_entry;

	assign id_miss = ~|id_hit;
	// new branch or jump not yet in any way of its set
	assign alloc = !stall && (id_req.is_branch || id_req.is_jump) && id_miss;

	// jumps start strongly taken, branches weakly not-taken
	always_comb begin
		alloc_entry.valid  = 1'b1;
		alloc_entry.tag    = id_tag;
		alloc_entry.target = id_req.target;
		alloc_entry.ctr    = id_req.is_jump ? 2'b11 : 2'b01;
	end

	// write port arbitration
	// allocation wins over the EXE update
	always_comb begin
		way_wr_en = '0;
		wr_set    = update.set;
		wr_entry  = update.entry;
		if (alloc) begin
			way_wr_en[fifo_q[id_set]] = 1'b1;
			wr_set   = id_set;
			wr_entry = alloc_entry;
		end else if (!stall && update.valid) begin
			way_wr_en[update.way] = 1'b1;
		end
	end

	// advance the set pointer after each allocation, wraps over 4 ways
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < SETS; s++) begin
				fifo_q[s] <= '0;
			end
		end else if (alloc) begin
			fifo_q[id_set] <= fifo_q[id_set] + 1'b1;
		end
	end

	// a jump not in the table flushes the fetched sequential instruction
	assign jump_flush     = !stall && id_req.is_jump && id_miss;
	assign id_jump_in_bht = id_req.is_jump && !id_miss;

endmodule

//--- source/branch_resolver.sv
////////////////////////////////////////////////////////////////////////////
// branch resolver
// picks the IF prediction and resolves EXE branches against the ALU flags,
// producing the next-PC correction, flush and the table update
////////////////////////////////////////////////////////////////////////////

`include "bp_defs.svh"

module branch_resolver (
	input  logic                      stall,
	input  bp_entry_pkg::way_vec_t    if_hit,
	input  bp_entry_pkg::way_vec_t    exe_hit,
	input  bp_entry_pkg::entry_vec_t  if_entries,
	input  bp_entry_pkg::entry_vec_t  exe_entries,
	input  bp_ctrl_pkg::exe_req_t     exe_req,
	input  logic [`BP_SET_W-1:0]      exe_set,
	output logic                      if_prediction,
	output logic [`BP_PC_W-1:0]       if_pbt,
	output bp_ctrl_pkg::correction_e  exe_correction,
	output logic [`BP_PC_W-1:0]       exe_pbt,
	output logic [`BP_PC_W-1:0]       exe_cni,
	output logic                      branch_flush,
	output bp_ctrl_pkg::bht_update_t  update
);

	localparam int WAY_W = `BP_WAY_W;

	// entry of the single hitting way, zero on a miss
	function automatic bp_entry_pkg::bht_entry_t pick_entry(
		input bp_entry_pkg::way_vec_t   hit,
		input bp_entry_pkg::entry_vec_t entries
	);
		bp_entry_pkg::bht_entry_t sel;
		sel = '0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (hit == (bp_entry_pkg::way_vec_t'(1) << w)) begin
				sel = entries[w];
			end
		end
		return sel;
	endfunction

	// index of the hitting way
	function automatic logic [`BP_WAY_W-1:0] pick_way(input bp_entry_pkg::way_vec_t hit);
		logic [`BP_WAY_W-1:0] idx;
		idx = '0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (hit[w]) begin
				idx = WAY_W'(w);
			end
		end
		return idx;
	endfunction

	bp_entry_pkg::bht_entry_t if_ent;
	bp_entry_pkg::bht_entry_t exe_ent;
	bp_entry_pkg::bht_entry_t upd_entry;
	logic                     upd_valid;
	logic                     is_cond;
	logic                     is_compressed;
	logic                     taken;
	logic [1:0]               ctr_next;
	logic [1:0]               cni_step;

	////////////////////////////////////////////////////////////////////////////
	// IF prediction

	assign if_ent        = pick_entry(if_hit, if_entries);
	assign if_prediction = if_ent.ctr[1];
	assign if_pbt        = if_ent.target;

	////////////////////////////////////////////////////////////////////////////
	// EXE resolution

	assign exe_ent       = pick_entry(exe_hit, exe_entries);
	assign is_cond       = (exe_req.op != bp_ctrl_pkg::BR_NONE);
	assign is_compressed = (exe_req.op == bp_ctrl_pkg::BR_C_BEQZ) ||
	                       (exe_req.op == bp_ctrl_pkg::BR_C_BNEZ);

	// actual outcome from the compare flags
	always_comb begin
		case (exe_req.op)
			bp_ctrl_pkg::BR_BEQ,
			bp_ctrl_pkg::BR_C_BEQZ: taken = exe_req.z;
			bp_ctrl_pkg::BR_BNE,
			bp_ctrl_pkg::BR_C_BNEZ: taken = !exe_req.z;
			bp_ctrl_pkg::BR_BLT:    taken = exe_req.signed_less;
			bp_ctrl_pkg::BR_BGE:    taken = !exe_req.signed_less;
			bp_ctrl_pkg::BR_BLTU:   taken = exe_req.less;
			bp_ctrl_pkg::BR_BGEU:   taken = !exe_req.less;
			default:                taken = 1'b0;
		endcase
	end

	// saturating step toward the outcome
	always_comb begin
		ctr_next = exe_ent.ctr;
		if (taken && exe_ent.ctr != 2'b11) begin
			ctr_next = exe_ent.ctr + 2'b01;
		end else if (!taken && exe_ent.ctr != 2'b00) begin
			ctr_next = exe_ent.ctr - 2'b01;
		end
	end

	// correction code and rewritten entry
	always_comb begin
		exe_correction = bp_ctrl_pkg::CORR_NONE;
		upd_entry      = exe_ent;
		upd_valid      = 1'b0;
		if (exe_req.is_indirect) begin
			// register-based jump whose stored target went stale
			if (exe_req.target != exe_ent.target) begin
				exe_correction   = bp_ctrl_pkg::CORR_PBT;
				upd_entry.target = exe_req.target;
				upd_valid        = |exe_hit;
			end
		end else if (is_cond) begin
			if (exe_ent.ctr[1] != taken) begin
				exe_correction = taken ? bp_ctrl_pkg::CORR_PBT : bp_ctrl_pkg::CORR_CNI;
			end
			upd_entry.ctr = ctr_next;
			upd_valid     = |exe_hit && (ctr_next != exe_ent.ctr);
		end
	end

	assign branch_flush = !stall && (exe_correction != bp_ctrl_pkg::CORR_NONE);

	assign update.valid = upd_valid;
	assign update.set   = exe_set;
	assign update.way   = pick_way(exe_hit);
	assign update.entry = upd_entry;

	// next-PC candidates
	// CNI rebuilds the branch PC from tag and set, then steps past it
	assign exe_pbt  = exe_req.is_indirect ? exe_req.target : exe_ent.target;
	assign cni_step = is_compressed ? 2'd1 : 2'd2;
	assign exe_cni  = {exe_ent.tag[`BP_TAG_W-2:0], exe_set} +
	                  {{(`BP_PC_W-2){1'b0}}, cni_step};

endmodule

//--- source/branch_predictor.sv
////////////////////////////////////////////////////////////////////////////
// branch prediction unit
// 4-way, 64-entry branch history table serving IF, ID and EXE
////////////////////////////////////////////////////////////////////////////

`include "bp_defs.svh"

module branch_predictor (
	input  logic                      CLK,
	input  logic                      nrst,
	input  logic                      isr_running,
	input  logic                      stall,
	input  logic [`BP_PC_W-1:0]       if_pc,
	input  bp_ctrl_pkg::id_req_t      id_req,
	input  bp_ctrl_pkg::exe_req_t     exe_req,
	output logic                      if_prediction,
	output logic [`BP_PC_W-1:0]       if_pbt,
	output bp_ctrl_pkg::correction_e  exe_correction,
	output logic [`BP_PC_W-1:0]       exe_pbt,
	output logic [`BP_PC_W-1:0]       exe_cni,
	output logic                      branch_flush,
	output logic                      jump_flush,
	output logic                      id_jump_in_bht
);

	bp_entry_pkg::bht_key_t   if_key;
	bp_entry_pkg::bht_key_t   id_key;
	bp_entry_pkg::bht_key_t   exe_key;
	bp_entry_pkg::way_vec_t   if_hit;
	bp_entry_pkg::way_vec_t   id_hit;
	bp_entry_pkg::way_vec_t   exe_hit;
	bp_entry_pkg::entry_vec_t if_entries;
	bp_entry_pkg::entry_vec_t exe_entries;
	bp_entry_pkg::way_vec_t   way_wr_en;
	logic [`BP_SET_W-1:0]     wr_set;
	bp_entry_pkg::bht_entry_t wr_entry;
	bp_ctrl_pkg::bht_update_t update;

	// set from the low PC bits, tag is ISR bit over the rest
	assign if_key  = '{set: if_pc[`BP_SET_W-1:0],
	                   tag: {isr_running, if_pc[`BP_PC_W-1:`BP_SET_W]}};
	assign id_key  = '{set: id_req.pc[`BP_SET_W-1:0],
	                   tag: {isr_running, id_req.pc[`BP_PC_W-1:`BP_SET_W]}};
	assign exe_key = '{set: exe_req.pc[`BP_SET_W-1:0],
	                   tag: {isr_running, exe_req.pc[`BP_PC_W-1:`BP_SET_W]}};

	bht_fill_ctrl bht_fill_ctrl_i (
		.CLK(CLK), .nrst(nrst), .stall(stall), .id_req(id_req),
		.id_set(id_key.set), .id_tag(id_key.tag), .id_hit(id_hit), .update(update),
		.way_wr_en(way_wr_en), .wr_set(wr_set), .wr_entry(wr_entry),
		.jump_flush(jump_flush), .id_jump_in_bht(id_jump_in_bht)
	);

	// table ways share the write set and data, enabled one-hot
	for (genvar w = 0; w < `BP_WAYS; w++) begin : g_way
		bht_way bht_way_i (
			.CLK(CLK), .nrst(nrst),
			.if_key(if_key), .id_key(id_key), .exe_key(exe_key),
			.wr_en(way_wr_en[w]), .wr_set(wr_set), .wr_entry(wr_entry),
			.if_hit(if_hit[w]), .id_hit(id_hit[w]), .exe_hit(exe_hit[w]),
			.if_entry(if_entries[w]), .exe_entry(exe_entries[w])
		);
	end

	branch_resolver branch_resolver_i (
		.stall(stall), .if_hit(if_hit), .exe_hit(exe_hit),
		.if_entries(if_entries), .exe_entries(exe_entries),
		.exe_req(exe_req), .exe_set(exe_key.set),
		.if_prediction(if_prediction), .if_pbt(if_pbt),
		.exe_correction(exe_correction), .exe_pbt(exe_pbt), .exe_cni(exe_cni),
		.branch_flush(branch_flush), .update(update)
	);

endmodule

//--- testbench/tb_branch_predictor.sv
////////////////////////////////////////////////////////////////////////////
// branch predictor testbench
// reference table model with FIFO counters, directed and random stimulus,
// concurrent checks of every DUT output against the model
////////////////////////////////////////////////////////////////////////////

`include "bp_defs.svh"

module tb_branch_predictor;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SETS  = 1 << `BP_SET_W;
	localparam int WAY_W = `BP_WAY_W;
	// roughly 115 cycles of stimulus, the rest is margin
	localparam int MAX_CYCLES = 400;

	localparam logic [`BP_PC_W-1:0]  PC_BR    = 11'h123;
	localparam logic [`BP_PC_W-1:0]  TGT_BR   = 11'h040;
	localparam logic [`BP_PC_W-1:0]  PC_JMP   = 11'h2A5;
	localparam logic [`BP_PC_W-1:0]  TGT_JMP  = 11'h300;
	localparam logic [`BP_PC_W-1:0]  TGT_IND  = 11'h1F0;
	localparam logic [`BP_PC_W-1:0]  PC_STALL = 11'h0AB;
	localparam logic [`BP_SET_W-1:0] FIFO_SET = 4'h7;

	logic                     CLK;
	logic                     nrst;
	logic                     isr_running;
	logic                     stall;
	logic [`BP_PC_W-1:0]      if_pc;
	bp_ctrl_pkg::id_req_t     id_req;
	bp_ctrl_pkg::exe_req_t    exe_req;
	logic                     if_prediction;
	logic [`BP_PC_W-1:0]      if_pbt;
	bp_ctrl_pkg::correction_e exe_correction;
	logic [`BP_PC_W-1:0]      exe_pbt;
	logic [`BP_PC_W-1:0]      exe_cni;
	logic                     branch_flush;
	logic                     jump_flush;
	logic                     id_jump_in_bht;

	int seed      = 42028;
	int cycle_cnt = 0;

	////////////////////////////////////////////////////////////////////////////
	// reference model state and expected outputs

	bp_entry_pkg::bht_entry_t model_tbl [`BP_WAYS][SETS];
	logic [`BP_WAY_W-1:0]     model_fifo [SETS];

	logic [`BP_SET_W-1:0]     m_if_set;
	logic [`BP_SET_W-1:0]     m_id_set;
	logic [`BP_SET_W-1:0]     m_exe_set;
	logic [`BP_TAG_W-1:0]     m_if_tag;
	logic [`BP_TAG_W-1:0]     m_id_tag;
	logic [`BP_TAG_W-1:0]     m_exe_tag;
	logic                     m_id_hit;
	logic                     m_exe_hit;
	logic [`BP_WAY_W-1:0]     m_exe_way;
	logic                     m_taken;
	logic                     m_compr;
	logic                     m_alloc;
	logic                     m_upd_valid;
	bp_entry_pkg::bht_entry_t m_if_ent;
	bp_entry_pkg::bht_entry_t m_exe_ent;
	bp_entry_pkg::bht_entry_t m_upd_ent;

	logic                     exp_if_pred;
	logic [`BP_PC_W-1:0]      exp_if_pbt;
	bp_ctrl_pkg::correction_e exp_corr;
	logic [`BP_PC_W-1:0]      exp_exe_pbt;
	logic [`BP_PC_W-1:0]      exp_exe_cni;
	logic                     exp_bflush;
	logic                     exp_jflush;
	logic                     exp_jib;

	branch_predictor branch_predictor_i (
		.CLK(CLK), .nrst(nrst), .isr_running(isr_running), .stall(stall),
		.if_pc(if_pc), .id_req(id_req), .exe_req(exe_req),
		.if_prediction(if_prediction), .if_pbt(if_pbt),
		.exe_correction(exe_correction), .exe_pbt(exe_pbt), .exe_cni(exe_cni),
		.branch_flush(branch_flush), .jump_flush(jump_flush),
		.id_jump_in_bht(id_jump_in_bht)
	);

	// 4 ns clock period
	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// lookups, outcome and write decision from the current inputs
	always_comb begin
		m_if_set  = if_pc[`BP_SET_W-1:0];
		m_if_tag  = {isr_running, if_pc[`BP_PC_W-1:`BP_SET_W]};
		m_id_set  = id_req.pc[`BP_SET_W-1:0];
		m_id_tag  = {isr_running, id_req.pc[`BP_PC_W-1:`BP_SET_W]};
		m_exe_set = exe_req.pc[`BP_SET_W-1:0];
		m_exe_tag = {isr_running, exe_req.pc[`BP_PC_W-1:`BP_SET_W]};
		m_if_ent  = '0;
		m_exe_ent = '0;
		m_id_hit  = 1'b0;
		m_exe_hit = 1'b0;
		m_exe_way = '0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (model_tbl[w][m_if_set].valid && model_tbl[w][m_if_set].tag == m_if_tag) begin
				m_if_ent = model_tbl[w][m_if_set];
			end
			if (model_tbl[w][m_id_set].valid && model_tbl[w][m_id_set].tag == m_id_tag) begin
				m_id_hit = 1'b1;
			end
			if (model_tbl[w][m_exe_set].valid && model_tbl[w][m_exe_set].tag == m_exe_tag) begin
				m_exe_hit = 1'b1;
				m_exe_way = WAY_W'(w);
				m_exe_ent = model_tbl[w][m_exe_set];
			end
		end
		// branch outcome from the ALU flags
		case (exe_req.op)
			bp_ctrl_pkg::BR_BEQ:    m_taken = exe_req.z;
			bp_ctrl_pkg::BR_C_BEQZ: m_taken = exe_req.z;
			bp_ctrl_pkg::BR_BNE:    m_taken = !exe_req.z;
			bp_ctrl_pkg::BR_C_BNEZ: m_taken = !exe_req.z;
			bp_ctrl_pkg::BR_BLT:    m_taken = exe_req.signed_less;
			bp_ctrl_pkg::BR_BGE:    m_taken = !exe_req.signed_less;
			bp_ctrl_pkg::BR_BLTU:   m_taken = exe_req.less;
			bp_ctrl_pkg::BR_BGEU:   m_taken = !exe_req.less;
			default:                m_taken = 1'b0;
		endcase
		m_compr = (exe_req.op == bp_ctrl_pkg::BR_C_BEQZ) ||
		          (exe_req.op == bp_ctrl_pkg::BR_C_BNEZ);
		m_upd_ent   = m_exe_ent;
		m_upd_valid = 1'b0;
		exp_corr    = bp_ctrl_pkg::CORR_NONE;
		if (exe_req.is_indirect) begin
			// stale indirect target gets rewritten
			if (exe_req.target != m_exe_ent.target) begin
				exp_corr         = bp_ctrl_pkg::CORR_PBT;
				m_upd_ent.target = exe_req.target;
				m_upd_valid      = m_exe_hit;
			end
		end else if (exe_req.op != bp_ctrl_pkg::BR_NONE) begin
			if (m_exe_ent.ctr[1] != m_taken) begin
				exp_corr = m_taken ? bp_ctrl_pkg::CORR_PBT : bp_ctrl_pkg::CORR_CNI;
			end
			// saturating counter step
			if (m_taken && m_exe_ent.ctr != 2'b11) begin
				m_upd_ent.ctr = m_exe_ent.ctr + 2'd1;
				m_upd_valid   = m_exe_hit;
			end else if (!m_taken && m_exe_ent.ctr != 2'b00) begin
				m_upd_ent.ctr = m_exe_ent.ctr - 2'd1;
				m_upd_valid   = m_exe_hit;
			end
		end
		m_alloc     = !stall && (id_req.is_branch || id_req.is_jump) && !m_id_hit;
		exp_if_pred = m_if_ent.ctr[1];
		exp_if_pbt  = m_if_ent.target;
		exp_exe_pbt = exe_req.is_indirect ? exe_req.target : m_exe_ent.target;
		// a hit stores the request PC bits in its tag, a miss leaves only the set
		exp_exe_cni = (m_exe_hit ? exe_req.pc : {{(`BP_PC_W-`BP_SET_W){1'b0}}, m_exe_set}) +
		              (m_compr ? 11'd1 : 11'd2);
		exp_bflush  = !stall && (exp_corr != bp_ctrl_pkg::CORR_NONE);
		exp_jflush  = !stall && id_req.is_jump && !m_id_hit;
		exp_jib     = id_req.is_jump && m_id_hit;
	end

	// table writes, allocation before EXE update
	always @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < SETS; s++) begin
				model_fifo[s] <= '0;
				for (int w = 0; w < `BP_WAYS; w++) begin
					model_tbl[w][s] <= '0;
				end
			end
		end else if (m_alloc) begin
			model_tbl[model_fifo[m_id_set]][m_id_set] <= '{valid: 1'b1, tag: m_id_tag,
				target: id_req.target, ctr: (id_req.is_jump ? 2'b11 : 2'b01)};
			model_fifo[m_id_set] <= model_fifo[m_id_set] + 2'd1;
		end else if (!stall && m_upd_valid) begin
			model_tbl[m_exe_way][m_exe_set] <= m_upd_ent;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks, sampled mid-cycle where inputs and state are settled

	chk_if_pred: assert property (@(negedge CLK) disable iff (!nrst)
		if_prediction == exp_if_pred)
		else report_mismatch($sformatf("if_prediction %0b, expected %0b", if_prediction, exp_if_pred));
	chk_if_pbt: assert property (@(negedge CLK) disable iff (!nrst) if_pbt == exp_if_pbt)
		else report_mismatch($sformatf("if_pbt %h, expected %h", if_pbt, exp_if_pbt));
	chk_corr: assert property (@(negedge CLK) disable iff (!nrst) exe_correction == exp_corr)
		else report_mismatch($sformatf("exe_correction %b, expected %b", exe_correction, exp_corr));
	chk_exe_pbt: assert property (@(negedge CLK) disable iff (!nrst) exe_pbt == exp_exe_pbt)
		else report_mismatch($sformatf("exe_pbt %h, expected %h", exe_pbt, exp_exe_pbt));
	chk_exe_cni: assert property (@(negedge CLK) disable iff (!nrst) exe_cni == exp_exe_cni)
		else report_mismatch($sformatf("exe_cni %h, expected %h", exe_cni, exp_exe_cni));
	chk_bflush: assert property (@(negedge CLK) disable iff (!nrst) branch_flush == exp_bflush)
		else report_mismatch($sformatf("branch_flush %0b, expected %0b", branch_flush, exp_bflush));
	chk_jflush: assert property (@(negedge CLK) disable iff (!nrst) jump_flush == exp_jflush)
		else report_mismatch($sformatf("jump_flush %0b, expected %0b", jump_flush, exp_jflush));
	chk_jib: assert property (@(negedge CLK) disable iff (!nrst) id_jump_in_bht == exp_jib)
		else report_mismatch($sformatf("id_jump_in_bht %0b, expected %0b", id_jump_in_bht, exp_jib));

	task automatic stop_failed();
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		stop_failed();
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_slot();
		@(posedge CLK);
		#1;
	endtask

	task automatic clear_inputs();
		stall   = 1'b0;
		id_req  = '0;
		exe_req = '0;
	endtask

	// conditional branch in EXE with random op and flags
	task automatic drive_random_exe(input logic [`BP_PC_W-1:0] pc);
		int r;
		r = $random(seed);
		exe_req             = '0;
		exe_req.pc          = pc;
		exe_req.target      = 11'(r >> 8);
		exe_req.op          = bp_ctrl_pkg::br_op_e'(4'(1 + ((r >> 4) & 7)));
		exe_req.z           = r[0];
		exe_req.less        = r[1];
		exe_req.signed_less = r[2];
	endtask

	// 32 PCs over sets 0..3, enough to force hits and evictions
	function automatic logic [`BP_PC_W-1:0] pool_pc(input int r);
		return {4'b0000, r[4:2], 2'b00, r[1:0]};
	endfunction

	initial begin
		wait (cycle_cnt >= MAX_CYCLES);
		$display("Timeout: no result after %0d clock cycles", MAX_CYCLES);
		stop_failed();
	end

	initial begin
		int r;
		CLK         = 1'b0;
		nrst        = 1'b0;
		isr_running = 1'b0;
		if_pc       = '0;
		clear_inputs();
		repeat (2) @(posedge CLK);
		#1;
		nrst = 1'b1;
		// empty table, idle inputs
		for (int i = 0; i < 8; i++) begin
			r          = $random(seed);
			if_pc      = 11'(r);
			exe_req.pc = 11'(r >> 11);
			next_slot();
		end
		// branch allocation, then jump allocation and jump hit
		id_req = '{pc: PC_BR, target: TGT_BR, is_jump: 1'b0, is_branch: 1'b1};
		if_pc  = PC_BR;
		next_slot();
		id_req = '0;
		next_slot();
		id_req = '{pc: PC_JMP, target: TGT_JMP, is_jump: 1'b1, is_branch: 1'b0};
		if_pc  = PC_JMP;
		next_slot();
		next_slot();
		id_req = '0;
		// counter training with random flags, some EXE misses mixed in
		for (int i = 0; i < 32; i++) begin
			if_pc = PC_BR;
			drive_random_exe((i % 4 == 3) ? pool_pc($random(seed)) : PC_BR);
			next_slot();
		end
		// indirect jump with a new target, then the same again
		exe_req             = '0;
		exe_req.pc          = PC_JMP;
		exe_req.target      = TGT_IND;
		exe_req.is_indirect = 1'b1;
		if_pc               = PC_JMP;
		next_slot();
		next_slot();
		exe_req = '0;
		// five tags into one set, the first one gets evicted
		for (int k = 1; k <= 5; k++) begin
			id_req = '{pc: {7'(k), FIFO_SET}, target: 11'(k * 16), is_jump: 1'b0, is_branch: 1'b1};
			next_slot();
		end
		id_req = '0;
		if_pc  = {7'd1, FIFO_SET};
		next_slot();
		if_pc = {7'd5, FIFO_SET};
		next_slot();
		// same PC inside an ISR is a separate entry
		isr_running = 1'b1;
		id_req      = '{pc: {7'd5, FIFO_SET}, target: 11'h7AA, is_jump: 1'b0, is_branch: 1'b1};
		next_slot();
		id_req = '0;
		next_slot();
		isr_running = 1'b0;
		next_slot();
		// stalled: no write, no flush
		stall  = 1'b1;
		id_req = '{pc: PC_STALL, target: 11'h155, is_jump: 1'b1, is_branch: 1'b0};
		if_pc  = PC_STALL;
		for (int i = 0; i < 6; i++) begin
			drive_random_exe(PC_BR);
			next_slot();
		end
		clear_inputs();
		next_slot();
		// random traffic on all three stages
		for (int i = 0; i < 48; i++) begin
			r           = $random(seed);
			stall       = (r[2:0] == 3'd0);
			isr_running = (r[7:4] == 4'd0);
			if_pc       = pool_pc(r >> 8);
			id_req      = '{pc: pool_pc(r >> 13), target: 11'(r >> 18), is_jump: r[29],
			                is_branch: r[30]};
			drive_random_exe(pool_pc(r >> 23));
			exe_req.is_indirect = r[31] & r[3];
			next_slot();
		end
		clear_inputs();
		next_slot();
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- branch_predictor.f
+incdir+source
source/bp_entry_pkg.sv
source/bp_ctrl_pkg.sv
source/bht_way.sv
source/bht_fill_ctrl.sv
source/branch_resolver.sv
source/branch_predictor.sv
testbench/tb_branch_predictor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_branch_predictor \
	-f branch_predictor.f \
	--Mdir obj_dir -o sim_branch_predictor
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_branch_predictor > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
